// ==== all.f ====
src/ethpipe_pkg.sv
src/slave_regs.sv
src/irq_moderator.sv
src/tx_slot_ram.sv
src/gmii_sender.sv
src/ethpipe_top.sv
test/tb_ethpipe.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_ethpipe -f all.f -o sim_ethpipe
./obj_dir/sim_ethpipe > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
grep -q "Simulation PASSED" sim.log

// ==== src/ethpipe_pkg.sv ====
`default_nettype none

package ethpipe_pkg;

  // ------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------
  localparam int unsigned DATA_W     = 16;
  localparam int unsigned ADR_W      = 19;
  localparam int unsigned SLOT_AW    = 11;
  localparam int unsigned SLOT_WORDS = 2048;
  localparam int unsigned PTR_W      = 16;
  localparam int unsigned CNT_W      = 64;
  localparam int unsigned INTR_W     = 32;

  localparam logic [INTR_W-1:0] INTR_DEFAULT = 32'd2500000;

  // gmii framing
  localparam int unsigned PREAMBLE_LEN    = 7;
  localparam logic [7:0]  PREAMBLE_BYTE   = 8'h55;
  localparam logic [7:0]  SFD_BYTE        = 8'hD5;
  localparam int unsigned IFG_CYCLES      = 12;
  localparam int unsigned MAX_FRAME_BYTES = 1518;

  // bar hit bit positions
  localparam int unsigned BAR_REGS = 0;
  localparam int unsigned BAR_SLOT = 2;

  // BAR0 word addresses, slave address bits 8 to 1
  typedef enum logic [7:0] {
    REG_GCNT0       = 8'h02,
    REG_GCNT1       = 8'h03,
    REG_GCNT2       = 8'h04,
    REG_GCNT3       = 8'h05,
    REG_STATUS      = 8'h08,
    REG_TX_WR_PTR   = 8'h18,
    REG_TX_RD_PTR   = 8'h1A,
    REG_CLR_INTR_LO = 8'h40,
    REG_CLR_INTR_HI = 8'h41,
    REG_SET_INTR_LO = 8'h42,
    REG_SET_INTR_HI = 8'h43
  } slv_reg_e;

  // slave bus request, adr keeps the byte address numbering 19..1
  typedef struct packed {
    logic              ce;
    logic              we;
    logic [6:0]        bar;
    logic [ADR_W:1]    adr;
    logic [DATA_W-1:0] dat;
    logic [1:0]        sel;
  } slv_req_t;

  typedef struct packed {
    logic       vld;
    logic [7:0] data;
  } status_wr_t;

  typedef struct packed {
    logic [INTR_W-1:0] clr_val;
    logic [INTR_W-1:0] set_val;
  } intr_cfg_t;

endpackage

`default_nettype wire

// ==== src/ethpipe_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module ethpipe_top
  import ethpipe_pkg::*;
(
  input  wire               clk_125,
  input  wire               sys_rst,
  input  wire slv_req_t     slv_req_i,
  output logic [DATA_W-1:0] slv_dat_o,
  output logic              gmii_tx_en_o,
  output logic [7:0]        gmii_txd_o,
  output logic              sys_intr_o
);

  logic [DATA_W-1:0]  regs_dat;
  logic [DATA_W-1:0]  slot_dat;
  logic [DATA_W-1:0]  snd_q;
  logic [SLOT_AW-1:0] snd_addr;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [7:0]         status;
  status_wr_t         status_wr;
  intr_cfg_t          intr_cfg;
  logic               slot_half_free;
  logic               tx_done;
  logic               rd_regs_q;
  logic               rd_slot_q;

  slave_regs slave_regs_i (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .slv_req_i        (slv_req_i),
    .rd_ptr_i         (rd_ptr),
    .status_i         (status),
    .dat_o            (regs_dat),
    .wr_ptr_o         (wr_ptr),
    .status_wr_o      (status_wr),
    .intr_cfg_o       (intr_cfg),
    .slot_half_free_o (slot_half_free)
  );

  irq_moderator irq_moderator_i (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .status_wr_i      (status_wr),
    .intr_cfg_i       (intr_cfg),
    .tx_done_i        (tx_done),
    .slot_half_free_i (slot_half_free),
    .status_o         (status),
    .sys_intr_o       (sys_intr_o)
  );

  tx_slot_ram tx_slot_ram_i (
    .clk_125    (clk_125),
    .slv_req_i  (slv_req_i),
    .host_q_o   (slot_dat),
    .snd_addr_i (snd_addr),
    .snd_q_o    (snd_q)
  );

  gmii_sender gmii_sender_i (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .wr_ptr_i     (wr_ptr),
    .snd_q_i      (snd_q),
    .snd_addr_o   (snd_addr),
    .rd_ptr_o     (rd_ptr),
    .tx_done_o    (tx_done),
    .gmii_tx_en_o (gmii_tx_en_o),
    .gmii_txd_o   (gmii_txd_o)
  );

  // ------------------------------------------------------------
  // read data select, latched with each read request
  // ------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      rd_regs_q <= 1'b0;
      rd_slot_q <= 1'b0;
    end else if (slv_req_i.ce && !slv_req_i.we) begin
      rd_regs_q <= slv_req_i.bar[BAR_REGS];
      rd_slot_q <= slv_req_i.bar[BAR_SLOT] && !slv_req_i.adr[17];
    end
  end

  always_comb begin
    if (rd_regs_q)
      slv_dat_o = regs_dat;
    else if (rd_slot_q)
      slv_dat_o = slot_dat;
    else
      slv_dat_o = '0;
  end

endmodule

`default_nettype wire

// ==== src/gmii_sender.sv ====
`default_nettype none
`timescale 1ns/100ps

module gmii_sender
  import ethpipe_pkg::*;
(
  input  wire                clk_125,
  input  wire                sys_rst,
  input  wire [PTR_W-1:0]    wr_ptr_i,
  input  wire [DATA_W-1:0]   snd_q_i,
  output logic [SLOT_AW-1:0] snd_addr_o,
  output logic [PTR_W-1:0]   rd_ptr_o,
  output logic               tx_done_o,
  output logic               gmii_tx_en_o,
  output logic [7:0]         gmii_txd_o
);

  typedef enum logic [2:0] {
    IDLE,
    FETCH_LEN,
    PREAMBLE,
    PAYLOAD,
    GAP
  } snd_state_e;

  snd_state_e                           state_q;
  logic [$clog2(MAX_FRAME_BYTES+1)-1:0] len_q;
  logic [$clog2(MAX_FRAME_BYTES+1)-1:0] cnt_q;
  logic [DATA_W-1:0]                    word_q;
  logic [SLOT_AW:0]                     frame_words;
  logic [SLOT_AW-1:0]                   next_rd;
  logic                                 last_byte;
  logic                                 load_word;

  // length word plus ceil(L/2) data words
  assign frame_words = ((SLOT_AW + 1)'(len_q) + 1'b1) >> 1;
  assign next_rd     = rd_ptr_o[SLOT_AW-1:0] + 1'b1 + frame_words[SLOT_AW-1:0];
  assign last_byte   = (cnt_q == len_q - 1'b1);

  // next byte opens a new word, so take it from the ram and prefetch the one after
  assign load_word = ((state_q == PREAMBLE) && (cnt_q == PREAMBLE_LEN)) ||
                     ((state_q == PAYLOAD) && cnt_q[0] && !last_byte);

  always_ff @(posedge clk_125) begin
    if (state_q == FETCH_LEN)
      len_q <= snd_q_i[$clog2(MAX_FRAME_BYTES+1)-1:0];
    if (load_word)
      word_q <= snd_q_i;
  end

  // ------------------------------------------------------------
  // frame FSM, gmii outputs are registered
  // ------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state_q      <= IDLE;
      cnt_q        <= '0;
      snd_addr_o   <= '0;
      rd_ptr_o     <= '0;
      tx_done_o    <= 1'b0;
      gmii_tx_en_o <= 1'b0;
      gmii_txd_o   <= '0;
    end else begin
      tx_done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (wr_ptr_i[SLOT_AW-1:0] != rd_ptr_o[SLOT_AW-1:0]) begin
            // ram samples the length word on this edge
            snd_addr_o <= snd_addr_o + 1'b1;
            state_q    <= FETCH_LEN;
          end
        end
        FETCH_LEN: begin
          cnt_q        <= '0;
          gmii_tx_en_o <= 1'b1;
          gmii_txd_o   <= PREAMBLE_BYTE;
          state_q      <= PREAMBLE;
        end
        PREAMBLE: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == PREAMBLE_LEN - 1) begin
            gmii_txd_o <= SFD_BYTE;
          end else if (load_word) begin
            gmii_txd_o <= snd_q_i[15:8];
            snd_addr_o <= snd_addr_o + 1'b1;
            cnt_q      <= '0;
            state_q    <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_byte) begin
            gmii_tx_en_o <= 1'b0;
            gmii_txd_o   <= '0;
            tx_done_o    <= 1'b1;
            rd_ptr_o     <= PTR_W'(next_rd);
            snd_addr_o   <= next_rd;
            cnt_q        <= '0;
            state_q      <= GAP;
          end else if (load_word) begin
            gmii_txd_o <= snd_q_i[15:8];
            snd_addr_o <= snd_addr_o + 1'b1;
          end else begin
            gmii_txd_o <= word_q[7:0];
          end
        end
        GAP: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == IFG_CYCLES - 1)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // the host must place a legal length ahead of each frame
  assert property (@(posedge clk_125) disable iff (sys_rst)
    (state_q == FETCH_LEN) |-> (snd_q_i >= 1 && snd_q_i <= MAX_FRAME_BYTES));

endmodule

`default_nettype wire

// ==== src/irq_moderator.sv ====
`default_nettype none
`timescale 1ns/100ps

module irq_moderator
  import ethpipe_pkg::*;
(
  input  wire              clk_125,
  input  wire              sys_rst,
  input  wire status_wr_t  status_wr_i,
  input  wire intr_cfg_t   intr_cfg_i,
  input  wire              tx_done_i,
  input  wire              slot_half_free_i,
  output logic [7:0]       status_o,
  output logic             sys_intr_o
);

  logic [7:0]        status_q;
  logic [INTR_W-1:0] holdoff_q;
  logic [INTR_W-1:0] hold_q;

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      status_q  <= '0;
      holdoff_q <= '0;
      hold_q    <= '0;
    end else if (status_wr_i.vld) begin
      status_q <= status_wr_i.data;
      hold_q   <= '0;
      // acknowledging tx done opens a new hold-off window
      if (!status_wr_i.data[3])
        holdoff_q <= intr_cfg_i.clr_val;
      else if (holdoff_q != '0)
        holdoff_q <= holdoff_q - 1'b1;
    end else begin
      if (holdoff_q != '0)
        holdoff_q <= holdoff_q - 1'b1;

      // bit 3 stays up for set_val cycles
      if (status_q[3]) begin
        if (hold_q == intr_cfg_i.set_val) begin
          status_q[3] <= 1'b0;
          hold_q      <= '0;
        end else begin
          hold_q <= hold_q + 1'b1;
        end
      end else begin
        hold_q <= '0;
      end

      if (tx_done_i && (holdoff_q == '0))
        status_q[3] <= 1'b1;

      // sticky until the host writes it clear
      if (slot_half_free_i)
        status_q[4] <= 1'b1;
    end
  end

  assign status_o   = status_q;
  assign sys_intr_o = status_q[3] | status_q[4];

  // with a steady set_val the hold window never overruns
  assert property (@(posedge clk_125) disable iff (sys_rst)
    (status_q[3] && $stable(intr_cfg_i.set_val)) |-> (hold_q <= intr_cfg_i.set_val));

endmodule

`default_nettype wire

// ==== src/slave_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

module slave_regs
  import ethpipe_pkg::*;
(
  input  wire                clk_125,
  input  wire                sys_rst,
  input  wire slv_req_t      slv_req_i,
  input  wire [PTR_W-1:0]    rd_ptr_i,
  input  wire [7:0]          status_i,
  output logic [DATA_W-1:0]  dat_o,
  output logic [PTR_W-1:0]   wr_ptr_o,
  output status_wr_t         status_wr_o,
  output intr_cfg_t          intr_cfg_o,
  output logic               slot_half_free_o
);

  logic [CNT_W-1:0]   gcnt_q;
  logic               adr_ok;
  logic               reg_wr;
  logic               reg_rd;
  slv_reg_e           reg_adr;
  logic [SLOT_AW-1:0] used_words;
  logic [SLOT_AW:0]   free_words;

  // register byte 0 lives on bus bits 15:8
  function automatic logic [15:0] swap16(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  function automatic logic [15:0] lane_merge(input logic [15:0] old_v,
                                             input logic [15:0] bus_v,
                                             input logic [1:0]  sel);
    logic [15:0] v;
    v = old_v;
    if (sel[1])
      v[7:0] = bus_v[15:8];
    if (sel[0])
      v[15:8] = bus_v[7:0];
    return v;
  endfunction

  assign adr_ok  = (slv_req_i.adr[11:9] == 3'b000);
  assign reg_adr = slv_reg_e'(slv_req_i.adr[8:1]);
  assign reg_wr  = slv_req_i.ce && slv_req_i.we && slv_req_i.bar[BAR_REGS] && adr_ok;
  assign reg_rd  = slv_req_i.ce && !slv_req_i.we && slv_req_i.bar[BAR_REGS];

  assign status_wr_o = '{
    vld:  reg_wr && (reg_adr == REG_STATUS) && slv_req_i.sel[1],
    data: slv_req_i.dat[15:8]
  };

  // free running global counter
  always_ff @(posedge clk_125) begin
    if (sys_rst)
      gcnt_q <= '0;
    else
      gcnt_q <= gcnt_q + 1'b1;
  end

  // ------------------------------------------------------------
  // host writes
  // ------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      wr_ptr_o           <= '0;
      intr_cfg_o.clr_val <= INTR_DEFAULT;
      intr_cfg_o.set_val <= INTR_DEFAULT;
    end else if (reg_wr) begin
      case (reg_adr)
        REG_TX_WR_PTR:   wr_ptr_o <= lane_merge(wr_ptr_o, slv_req_i.dat, slv_req_i.sel);
        REG_CLR_INTR_LO: intr_cfg_o.clr_val[15:0] <=
          lane_merge(intr_cfg_o.clr_val[15:0], slv_req_i.dat, slv_req_i.sel);
        REG_CLR_INTR_HI: intr_cfg_o.clr_val[31:16] <=
          lane_merge(intr_cfg_o.clr_val[31:16], slv_req_i.dat, slv_req_i.sel);
        REG_SET_INTR_LO: intr_cfg_o.set_val[15:0] <=
          lane_merge(intr_cfg_o.set_val[15:0], slv_req_i.dat, slv_req_i.sel);
        REG_SET_INTR_HI: intr_cfg_o.set_val[31:16] <=
          lane_merge(intr_cfg_o.set_val[31:16], slv_req_i.dat, slv_req_i.sel);
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // host reads, data held until the next BAR0 read
  // ------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      dat_o <= '0;
    end else if (reg_rd) begin
      if (!adr_ok) begin
        dat_o <= '0;
      end else begin
        case (reg_adr)
          REG_GCNT0:       dat_o <= swap16(gcnt_q[15:0]);
          REG_GCNT1:       dat_o <= swap16(gcnt_q[31:16]);
          REG_GCNT2:       dat_o <= swap16(gcnt_q[47:32]);
          REG_GCNT3:       dat_o <= swap16(gcnt_q[63:48]);
          REG_STATUS:      dat_o <= {status_i, 8'h00};
          REG_TX_WR_PTR:   dat_o <= swap16(wr_ptr_o);
          REG_TX_RD_PTR:   dat_o <= swap16(rd_ptr_i);
          REG_CLR_INTR_LO: dat_o <= swap16(intr_cfg_o.clr_val[15:0]);
          REG_CLR_INTR_HI: dat_o <= swap16(intr_cfg_o.clr_val[31:16]);
          REG_SET_INTR_LO: dat_o <= swap16(intr_cfg_o.set_val[15:0]);
          REG_SET_INTR_HI: dat_o <= swap16(intr_cfg_o.set_val[31:16]);
          default:         dat_o <= '0;
        endcase
      end
    end
  end

  // slot occupancy, pointers wrap at the slot depth
  assign used_words = wr_ptr_o[SLOT_AW-1:0] - rd_ptr_i[SLOT_AW-1:0];
  assign free_words = (SLOT_AW + 1)'(SLOT_WORDS) - {1'b0, used_words};

  always_ff @(posedge clk_125) begin
    if (sys_rst)
      slot_half_free_o <= 1'b0;
    else
      slot_half_free_o <= (free_words >= (SLOT_AW + 1)'(SLOT_WORDS / 2));
  end

  // a register write always carries at least one byte lane
  assert property (@(posedge clk_125) disable iff (sys_rst)
    (slv_req_i.ce && slv_req_i.we && slv_req_i.bar[BAR_REGS]) |-> (slv_req_i.sel != 2'b00));

endmodule

`default_nettype wire

// ==== src/tx_slot_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

module tx_slot_ram
  import ethpipe_pkg::*;
(
  input  wire                clk_125,
  input  wire slv_req_t      slv_req_i,
  output logic [DATA_W-1:0]  host_q_o,
  input  wire [SLOT_AW-1:0]  snd_addr_i,
  output logic [DATA_W-1:0]  snd_q_o
);

  logic [DATA_W-1:0]  mem_q [SLOT_WORDS];
  logic               host_en;
  logic [SLOT_AW-1:0] host_addr;

  // lower half of BAR2 holds the slot of this PHY
  assign host_en   = slv_req_i.ce && slv_req_i.bar[BAR_SLOT] && !slv_req_i.adr[17];
  assign host_addr = slv_req_i.adr[SLOT_AW:1];

  // host port with per lane writes
  always_ff @(posedge clk_125) begin
    if (host_en) begin
      if (slv_req_i.we) begin
        if (slv_req_i.sel[1])
          mem_q[host_addr][15:8] <= slv_req_i.dat[15:8];
        if (slv_req_i.sel[0])
          mem_q[host_addr][7:0] <= slv_req_i.dat[7:0];
      end else begin
        host_q_o <= mem_q[host_addr];
      end
    end
  end

  // sender port, read only
  always_ff @(posedge clk_125) begin
    snd_q_o <= mem_q[snd_addr_i];
  end

endmodule

`default_nettype wire

// ==== test/tb_ethpipe.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_ethpipe
  import ethpipe_pkg::*;
();

  typedef enum {OP_WR, OP_RD, OP_LOAD, OP_FRAME, OP_IRQ, OP_GCNT} op_e;

  typedef struct {
    op_e         op;
    logic [6:0]  bar;
    int unsigned adr;
    logic [15:0] dat;
    logic [1:0]  sel;
    logic [15:0] exp;
    string       name;
  } step_t;

  localparam logic [6:0] BAR0_HIT = 7'b0000001;
  localparam logic [6:0] BAR1_HIT = 7'b0000010;
  localparam logic [6:0] BAR2_HIT = 7'b0000100;
  // largest set_val that the table programs
  localparam int unsigned SET_VAL_MAX = 20;

  logic              clk_125;
  logic              sys_rst;
  slv_req_t          req;
  logic [DATA_W-1:0] slv_dat;
  logic              gmii_tx_en;
  logic [7:0]        gmii_txd;
  logic              sys_intr;

  step_t       steps[$];
  logic [7:0]  exp_bytes[$];
  int unsigned exp_lens[$];
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;

  ethpipe_top ethpipe_top_i (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .slv_req_i    (req),
    .slv_dat_o    (slv_dat),
    .gmii_tx_en_o (gmii_tx_en),
    .gmii_txd_o   (gmii_txd),
    .sys_intr_o   (sys_intr)
  );

  initial begin
    clk_125 = 1'b0;
    forever #2 clk_125 = ~clk_125;
  end

  always @(posedge clk_125) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    assert (act_v === exp_v)
      else report_failure($sformatf("FAILED %s expected %h actual %h", name, exp_v, act_v));
  endtask

  task automatic add_step(input op_e op, input logic [6:0] bar, input int unsigned adr,
                          input logic [15:0] dat, input logic [1:0] sel,
                          input logic [15:0] exp, input string name);
    step_t s;
    s.op   = op;
    s.bar  = bar;
    s.adr  = adr;
    s.dat  = dat;
    s.sel  = sel;
    s.exp  = exp;
    s.name = name;
    steps.push_back(s);
  endtask

  // one bus request, inputs change 0.5 ns after the edge
  task automatic bus_cycle(input logic we, input logic [6:0] bar, input int unsigned adr,
                           input logic [15:0] dat, input logic [1:0] sel);
    req.ce  = 1'b1;
    req.we  = we;
    req.bar = bar;
    req.adr = ADR_W'(adr);
    req.dat = dat;
    req.sel = sel;
    @(posedge clk_125);
    #0.5;
    req = '0;
  endtask

  // length word then payload, high byte of each word goes out first
  task automatic load_frame(input int unsigned start, input int unsigned len);
    int unsigned nwords;
    logic [7:0]  hi;
    logic [7:0]  lo;
    nwords = (len + 1) / 2;
    bus_cycle(1'b1, BAR2_HIT, start % SLOT_WORDS, 16'(len), 2'b11);
    for (int unsigned i = 0; i < nwords; i++) begin
      hi = 8'($urandom());
      lo = 8'($urandom());
      exp_bytes.push_back(hi);
      if (2 * i + 1 < len)
        exp_bytes.push_back(lo);
      bus_cycle(1'b1, BAR2_HIT, (start + 1 + i) % SLOT_WORDS, {hi, lo}, 2'b11);
    end
    exp_lens.push_back(len);
  endtask

  // ------------------------------------------------------------
  // gmii byte monitor
  // ------------------------------------------------------------
  task automatic watch_frame(input string name);
    int unsigned len;
    logic [7:0]  exp_b;
    len = exp_lens.pop_front();
    while (!gmii_tx_en) begin
      @(posedge clk_125);
      #0.5;
    end
    for (int unsigned k = 0; k < PREAMBLE_LEN + 1 + len; k++) begin
      if (k < PREAMBLE_LEN)
        exp_b = PREAMBLE_BYTE;
      else if (k == PREAMBLE_LEN)
        exp_b = SFD_BYTE;
      else
        exp_b = exp_bytes.pop_front();
      assert (gmii_tx_en)
        else report_failure($sformatf("%s: tx enable dropped at byte %0d", name, k));
      check_value($sformatf("%s byte %0d", name, k), {8'h00, exp_b}, {8'h00, gmii_txd});
      @(posedge clk_125);
      #0.5;
    end
    assert (!gmii_tx_en)
      else report_failure($sformatf("%s: tx enable still high after the last byte", name));
  endtask

  // polls status every cycle, starting on the cycle where tx enable fell
  task automatic watch_tx_irq(input string name);
    int unsigned c;
    int unsigned c_intr;
    int unsigned c_rise;
    int unsigned c_clear;
    c       = 0;
    c_intr  = 0;
    c_rise  = 0;
    c_clear = 0;
    while (c_clear == 0 && c < 40) begin
      req.ce  = 1'b1;
      req.we  = 1'b0;
      req.bar = BAR0_HIT;
      req.adr = ADR_W'(REG_STATUS);
      @(posedge clk_125);
      #0.5;
      c++;
      if (sys_intr && c_intr == 0)
        c_intr = c;
      // status bit 3 sits on bus bit 11
      if (c_rise == 0 && slv_dat[11])
        c_rise = c;
      else if (c_rise != 0 && !slv_dat[11])
        c_clear = c;
    end
    req = '0;
    assert (c_intr != 0 && c_intr <= 3)
      else report_failure($sformatf("%s: interrupt not raised within 3 cycles", name));
    assert (c_rise != 0 && c_rise <= 3)
      else report_failure($sformatf("%s: status bit 3 not set within 3 cycles", name));
    assert (c_clear >= 20 && c_clear <= 24)
      else report_failure($sformatf("%s: status bit 3 cleared at cycle %0d, not 20 to 24",
                                    name, c_clear));
    // bit 4 is still set, so the interrupt stays up after bit 3 clears
    assert (sys_intr)
      else report_failure($sformatf("%s: interrupt dropped while status bit 4 is set", name));
  endtask

  task automatic gcnt_step(input string name, input int unsigned n);
    logic [15:0] first_v;
    logic [15:0] second_v;
    bus_cycle(1'b0, BAR0_HIT, REG_GCNT0, 16'h0000, 2'b00);
    first_v = {slv_dat[7:0], slv_dat[15:8]};
    repeat (n - 1) begin
      @(posedge clk_125);
      #0.5;
    end
    bus_cycle(1'b0, BAR0_HIT, REG_GCNT0, 16'h0000, 2'b00);
    second_v = {slv_dat[7:0], slv_dat[15:8]};
    check_value(name, 16'(n), second_v - first_v);
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      OP_WR:    bus_cycle(1'b1, s.bar, s.adr, s.dat, s.sel);
      OP_RD: begin
        bus_cycle(1'b0, s.bar, s.adr, s.dat, s.sel);
        check_value(s.name, s.exp, slv_dat);
      end
      OP_LOAD:  load_frame(s.adr, s.dat);
      OP_FRAME: watch_frame(s.name);
      OP_IRQ:   watch_tx_irq(s.name);
      OP_GCNT:  gcnt_step(s.name, s.dat);
      default:  report_failure("unknown table operation");
    endcase
  endtask

  // ------------------------------------------------------------
  // stimulus table, register values in bus lane order
  // ------------------------------------------------------------
  task automatic build_table();
    add_step(OP_RD, BAR0_HIT, REG_TX_WR_PTR, 16'h0000, 2'b00, 16'h0000, "wr_ptr reset");
    add_step(OP_RD, BAR0_HIT, REG_TX_RD_PTR, 16'h0000, 2'b00, 16'h0000, "rd_ptr reset");
    add_step(OP_RD, BAR0_HIT, REG_STATUS, 16'h0000, 2'b00, 16'h1000, "status reset");
    add_step(OP_RD, BAR0_HIT, REG_CLR_INTR_LO, 16'h0000, 2'b00, 16'hA025, "clr lo reset");
    add_step(OP_RD, BAR0_HIT, REG_CLR_INTR_HI, 16'h0000, 2'b00, 16'h2600, "clr hi reset");
    add_step(OP_RD, BAR0_HIT, REG_SET_INTR_LO, 16'h0000, 2'b00, 16'hA025, "set lo reset");
    add_step(OP_RD, BAR0_HIT, REG_SET_INTR_HI, 16'h0000, 2'b00, 16'h2600, "set hi reset");
    // register read data still holds a nonzero value here
    add_step(OP_RD, BAR1_HIT, 'h000, 16'h0000, 2'b00, 16'h0000, "unmapped bar");
    add_step(OP_RD, BAR0_HIT, 'h010, 16'h0000, 2'b00, 16'h0000, "unmapped bar0");
    add_step(OP_RD, BAR0_HIT, 'h102, 16'h0000, 2'b00, 16'h0000, "bar0 high address");
    // byte 1 of wr_ptr only touches bits above the slot index
    add_step(OP_WR, BAR0_HIT, REG_TX_WR_PTR, 16'h00F8, 2'b01, 16'h0000, "wr_ptr byte 1");
    add_step(OP_RD, BAR0_HIT, REG_TX_WR_PTR, 16'h0000, 2'b00, 16'h00F8, "wr_ptr byte 1");
    add_step(OP_WR, BAR0_HIT, REG_TX_WR_PTR, 16'h0000, 2'b01, 16'h0000, "wr_ptr clear");
    add_step(OP_RD, BAR0_HIT, REG_TX_WR_PTR, 16'h0000, 2'b00, 16'h0000, "wr_ptr clear");
    add_step(OP_WR, BAR0_HIT, REG_SET_INTR_LO, 16'h1400, 2'b10, 16'h0000, "set lo byte 0");
    add_step(OP_RD, BAR0_HIT, REG_SET_INTR_LO, 16'h0000, 2'b00, 16'h1425, "set lo byte 0");
    add_step(OP_WR, BAR0_HIT, REG_SET_INTR_LO, 16'h0000, 2'b01, 16'h0000, "set lo byte 1");
    add_step(OP_RD, BAR0_HIT, REG_SET_INTR_LO, 16'h0000, 2'b00, 16'h1400, "set lo byte 1");
    add_step(OP_WR, BAR0_HIT, REG_SET_INTR_HI, 16'h0000, 2'b11, 16'h0000, "set hi");
    add_step(OP_RD, BAR0_HIT, REG_SET_INTR_HI, 16'h0000, 2'b00, 16'h0000, "set hi");
    add_step(OP_WR, BAR0_HIT, REG_CLR_INTR_LO, 16'h0000, 2'b01, 16'h0000, "clr lo byte 1");
    add_step(OP_RD, BAR0_HIT, REG_CLR_INTR_LO, 16'h0000, 2'b00, 16'hA000, "clr lo byte 1");
    add_step(OP_WR, BAR0_HIT, REG_CLR_INTR_LO, 16'h0000, 2'b10, 16'h0000, "clr lo byte 0");
    add_step(OP_RD, BAR0_HIT, REG_CLR_INTR_LO, 16'h0000, 2'b00, 16'h0000, "clr lo byte 0");
    add_step(OP_WR, BAR0_HIT, REG_CLR_INTR_HI, 16'h0000, 2'b11, 16'h0000, "clr hi");
    add_step(OP_RD, BAR0_HIT, REG_CLR_INTR_HI, 16'h0000, 2'b00, 16'h0000, "clr hi");
    add_step(OP_GCNT, BAR0_HIT, REG_GCNT0, 16'd5, 2'b00, 16'h0000, "global counter");
    // slot ram lanes are not swapped
    add_step(OP_WR, BAR2_HIT, 'h700, 16'h1234, 2'b11, 16'h0000, "slot full word");
    add_step(OP_WR, BAR2_HIT, 'h700, 16'hABCD, 2'b10, 16'h0000, "slot high lane");
    add_step(OP_WR, BAR2_HIT, 'h700, 16'h5566, 2'b01, 16'h0000, "slot low lane");
    add_step(OP_RD, BAR2_HIT, 'h700, 16'h0000, 2'b00, 16'hAB66, "slot merged word");
    add_step(OP_RD, BAR2_HIT, 'h10700, 16'h0000, 2'b00, 16'h0000, "bar2 upper half");
    // two frames, then the pointer moves past both
    add_step(OP_LOAD, BAR2_HIT, 0, 16'd9, 2'b11, 16'h0000, "frame a");
    add_step(OP_LOAD, BAR2_HIT, 6, 16'd14, 2'b11, 16'h0000, "frame b");
    add_step(OP_WR, BAR0_HIT, REG_TX_WR_PTR, 16'h0E00, 2'b10, 16'h0000, "start a and b");
    add_step(OP_FRAME, BAR0_HIT, 0, 16'h0000, 2'b00, 16'h0000, "frame a");
    add_step(OP_FRAME, BAR0_HIT, 0, 16'h0000, 2'b00, 16'h0000, "frame b");
    add_step(OP_RD, BAR0_HIT, REG_TX_RD_PTR, 16'h0000, 2'b00, 16'h0E00, "rd_ptr after b");
    add_step(OP_RD, BAR0_HIT, REG_TX_WR_PTR, 16'h0000, 2'b00, 16'h0E00, "wr_ptr after b");
    // set_val 20 and clr_val 0 from the lane writes above
    add_step(OP_LOAD, BAR2_HIT, 14, 16'd10, 2'b11, 16'h0000, "frame c");
    add_step(OP_WR, BAR0_HIT, REG_TX_WR_PTR, 16'h1400, 2'b10, 16'h0000, "start c");
    add_step(OP_FRAME, BAR0_HIT, 0, 16'h0000, 2'b00, 16'h0000, "frame c");
    add_step(OP_IRQ, BAR0_HIT, 0, 16'h0000, 2'b00, 16'h0000, "tx done interrupt");
    // hold-off of 1000 cycles
    add_step(OP_WR, BAR0_HIT, REG_CLR_INTR_LO, 16'hE803, 2'b11, 16'h0000, "clr 1000");
    add_step(OP_RD, BAR0_HIT, REG_CLR_INTR_LO, 16'h0000, 2'b00, 16'hE803, "clr 1000");
    add_step(OP_WR, BAR0_HIT, REG_STATUS, 16'h0000, 2'b10, 16'h0000, "status write");
    add_step(OP_RD, BAR0_HIT, REG_STATUS, 16'h0000, 2'b00, 16'h0000, "status cleared");
    add_step(OP_RD, BAR0_HIT, REG_STATUS, 16'h0000, 2'b00, 16'h1000, "half free again");
    add_step(OP_LOAD, BAR2_HIT, 20, 16'd6, 2'b11, 16'h0000, "frame d");
    add_step(OP_WR, BAR0_HIT, REG_TX_WR_PTR, 16'h1800, 2'b10, 16'h0000, "start d");
    add_step(OP_FRAME, BAR0_HIT, 0, 16'h0000, 2'b00, 16'h0000, "frame d");
    add_step(OP_RD, BAR0_HIT, REG_STATUS, 16'h0000, 2'b00, 16'h1000, "hold-off 1");
    add_step(OP_RD, BAR0_HIT, REG_STATUS, 16'h0000, 2'b00, 16'h1000, "hold-off 2");
    add_step(OP_RD, BAR0_HIT, REG_STATUS, 16'h0000, 2'b00, 16'h1000, "hold-off 3");
    add_step(OP_RD, BAR0_HIT, REG_TX_RD_PTR, 16'h0000, 2'b00, 16'h1800, "rd_ptr after d");
  endtask

  initial begin
    int unsigned limit;
    sys_rst = 1'b1;
    req     = '0;
    void'($urandom(32'h453d));
    build_table();

    // 4 cycles per step, frame bytes plus 40 per frame, longest hold, margin
    limit = steps.size() * 4 + SET_VAL_MAX + 200;
    foreach (steps[i]) begin
      if (steps[i].op == OP_LOAD)
        limit += steps[i].dat + 40;
      if (steps[i].op == OP_GCNT)
        limit += steps[i].dat;
    end
    cycle_limit = limit;

    repeat (3) @(posedge clk_125);
    #0.5;
    sys_rst = 1'b0;
    check_value("intr after reset", 16'h0000, {15'd0, sys_intr});
    check_value("tx enable after reset", 16'h0000, {15'd0, gmii_tx_en});
    check_value("read data after reset", 16'h0000, slv_dat);

    foreach (steps[i])
      run_step(steps[i]);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
